/* rtl/rv_pkg.sv */
// shared widths and encodings; memories are 64 words each, only the listed RV32I subset decodes
package rv_pkg;

  localparam int xlen       = 32;  // data and address width
  localparam int reg_addr_w = 5;   // 32 architectural registers

  localparam int imem_depth = 64;  // instruction words
  localparam int dmem_depth = 64;  // data words, byte addresses 0..255

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,  // add sub and or slt
    op_imm    = 7'b0010011,  // addi
    op_load   = 7'b0000011,  // lw
    op_store  = 7'b0100011,  // sw
    op_branch = 7'b1100011,  // beq bne
    op_system = 7'b1110011   // ecall
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4   // signed less-than, result 0 or 1
  } alu_op_e;

  // ecall halts when x17 == 10, otherwise no-op
  localparam reg_addr_t halt_reg  = 5'd17;
  localparam word_t     halt_code = 32'd10;

  // addi x0,x0,0 doubles as bubble in IF/ID
  localparam word_t nop_word = 32'h0000_0013;

endpackage

/* rtl/fetch_unit.sv */
// prog_addr is a word index, not a byte address; program load only lands while reset is high
`timescale 1ns/1ns

module fetch_unit (
  input  logic          clk,
  input  logic          reset,
  input  logic          prog_we,
  input  rv_pkg::word_t prog_addr,
  input  rv_pkg::word_t prog_data,
  input  logic          stall,
  input  logic          redirect,
  input  rv_pkg::word_t redirect_pc,
  output rv_pkg::word_t if_inst,
  output rv_pkg::word_t if_pc
);

  rv_pkg::word_t pc;
  rv_pkg::word_t fetch_word;
  rv_pkg::word_t imem [rv_pkg::imem_depth];

  // load port, program is written only during reset
  always_ff @(posedge clk) begin
    if (reset && prog_we) begin
      imem[prog_addr[$clog2(rv_pkg::imem_depth)-1:0]] <= prog_data;
    end
  end

  assign fetch_word = imem[pc[$clog2(rv_pkg::imem_depth)+1:2]];  // async read, wraps

  // pc, redirect beats stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;  // taken branch target
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // IF/ID register
  always_ff @(posedge clk) begin
    if (reset || redirect) begin
      if_inst <= rv_pkg::nop_word;  // flush the wrong-path word
      if_pc   <= '0;
    end else if (!stall) begin
      if_inst <= fetch_word;
      if_pc   <= pc;
    end
  end

  // targets come from execute, so alignment is a pipeline-wide property
  pc_aligned_a: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

/* rtl/decode_unit.sv */
// decodes only ADD SUB AND OR SLT ADDI LW SW BEQ BNE ECALL; other opcodes issue as no-ops
`timescale 1ns/1ns

module decode_unit (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::word_t     if_inst,
  input  rv_pkg::word_t     if_pc,
  input  logic              redirect,
  input  rv_pkg::reg_addr_t mem_rd,
  input  logic              mem_reg_write,
  input  logic              mem_mem_read,
  input  rv_pkg::reg_addr_t wb_rd,
  input  logic              wb_reg_write,
  input  rv_pkg::word_t     wb_data,
  input  rv_pkg::reg_addr_t dbg_addr,
  output rv_pkg::word_t     dbg_data,
  output logic              stall,
  output logic              ex_valid,
  output rv_pkg::alu_op_e   ex_alu_op,
  output logic              ex_use_imm,
  output logic              ex_is_branch,
  output logic              ex_branch_ne,
  output logic              ex_mem_read,
  output logic              ex_mem_write,
  output logic              ex_reg_write,
  output logic              ex_halt,
  output rv_pkg::reg_addr_t ex_rs1,
  output rv_pkg::reg_addr_t ex_rs2,
  output rv_pkg::reg_addr_t ex_rd,
  output rv_pkg::word_t     ex_rs1_data,
  output rv_pkg::word_t     ex_rs2_data,
  output rv_pkg::word_t     ex_imm,
  output rv_pkg::word_t     ex_pc
);

  rv_pkg::word_t     regs [32];  // x0 slot never written
  rv_pkg::opcode_e   opcode;
  logic [2:0]        funct3;
  rv_pkg::reg_addr_t rs1_sel, rs2, rd;
  rv_pkg::word_t     rs1_val, rs2_val, imm;
  rv_pkg::alu_op_e   alu_op;
  logic              use_imm, is_branch, mem_read, mem_write, reg_write, is_ecall;
  logic              uses_rs1, uses_rs2;
  logic              load_use, ecall_hazard, halt_hit, halt_q, issue;

  // funct3 to ALU op, alt picks sub for R-type
  function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b111:  return rv_pkg::alu_and;
      3'b110:  return rv_pkg::alu_or;
      3'b010:  return rv_pkg::alu_slt;
      default: return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
    endcase
  endfunction

  // read with x0 forced to zero and same-cycle writeback bypass
  function automatic rv_pkg::word_t rf_read(input rv_pkg::reg_addr_t a);
    if (a == '0) return '0;
    if (wb_reg_write && wb_rd == a) return wb_data;
    return regs[a];
  endfunction

  assign opcode  = rv_pkg::opcode_e'(if_inst[6:0]);
  assign funct3  = if_inst[14:12];
  assign rs2     = if_inst[24:20];
  assign rs1_sel = is_ecall ? rv_pkg::halt_reg : if_inst[19:15];  // ecall inspects x17

  always_comb begin
    alu_op    = rv_pkg::alu_add;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    is_ecall  = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    imm       = {{20{if_inst[31]}}, if_inst[31:20]};  // I-type default
    case (opcode)
      rv_pkg::op_reg: begin
        alu_op    = alu_from_funct(funct3, if_inst[30]);
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
      end
      rv_pkg::op_imm: begin
        alu_op    = alu_from_funct(funct3, 1'b0);  // no subi
        use_imm   = 1'b1;
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
      end
      rv_pkg::op_load: begin
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
      end
      rv_pkg::op_store: begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        imm       = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
      end
      rv_pkg::op_branch: begin
        alu_op    = rv_pkg::alu_sub;
        is_branch = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        imm       = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                     if_inst[11:8], 1'b0};
      end
      rv_pkg::op_system: begin
        is_ecall = 1'b1;
        uses_rs1 = 1'b1;
      end
      default: ;  // unsupported, falls through as no-op
    endcase
  end

  assign rd = if_inst[11:7];

  // register file
  always_ff @(posedge clk) begin
    if (wb_reg_write && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rs1_val  = rf_read(rs1_sel);
    rs2_val  = rf_read(rs2);
    dbg_data = rf_read(dbg_addr);  // debug port sees the bypass too
  end

  // hazards
  assign load_use = ex_mem_read && ex_rd != '0 &&
                    ((uses_rs1 && rs1_sel == ex_rd) || (uses_rs2 && rs2 == ex_rd));
  // x17 must have settled into the regfile or WB before ecall reads it
  assign ecall_hazard = is_ecall &&
                        ((ex_reg_write && ex_rd == rv_pkg::halt_reg) ||
                         (mem_reg_write && mem_rd == rv_pkg::halt_reg));
  assign stall    = load_use || ecall_hazard || halt_q;
  assign issue    = !redirect && !stall;
  assign halt_hit = is_ecall && rs1_val == rv_pkg::halt_code;

  // halt latch, cleared only by reset
  always_ff @(posedge clk) begin
    if (reset) begin
      halt_q <= 1'b0;
    end else if (issue && halt_hit) begin
      halt_q <= 1'b1;
    end
  end

  // ID/EX control, bubble on stall or flush
  always_ff @(posedge clk) begin
    if (reset || !issue) begin
      ex_valid     <= 1'b0;
      ex_is_branch <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_halt      <= 1'b0;
    end else begin
      ex_valid     <= 1'b1;
      ex_is_branch <= is_branch;
      ex_mem_read  <= mem_read;
      ex_mem_write <= mem_write;
      ex_reg_write <= reg_write && rd != '0;  // x0 writes dropped here
      ex_halt      <= halt_hit;
    end
  end

  // ID/EX payload, meaningless under a bubble
  always_ff @(posedge clk) begin
    ex_alu_op    <= alu_op;
    ex_use_imm   <= use_imm;
    ex_branch_ne <= funct3[0];               // bne vs beq
    ex_rs1       <= uses_rs1 ? rs1_sel : '0;  // zeroed so unused fields never forward
    ex_rs2       <= uses_rs2 ? rs2 : '0;
    ex_rd        <= rd;
    ex_rs1_data  <= rs1_val;
    ex_rs2_data  <= rs2_val;
    ex_imm       <= imm;
    ex_pc        <= if_pc;
  end

  // flush must win, IF/ID may not keep a held word
  flush_over_stall_a: assert property (@(posedge clk) disable iff (reset)
    redirect && stall |=> if_inst == rv_pkg::nop_word);

  // a load in MEM never feeds EX directly, the load-use stall covers it
  load_use_covered_a: assert property (@(posedge clk) disable iff (reset)
    mem_mem_read && mem_reg_write && ex_valid |->
      !(ex_rs1 == mem_rd || ex_rs2 == mem_rd));

endmodule

/* rtl/execute_unit.sv */
// forwarding assumes a load in MEM never feeds EX, decode stalls that case
`timescale 1ns/1ns

module execute_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              ex_valid,
  input  rv_pkg::alu_op_e   ex_alu_op,
  input  logic              ex_use_imm,
  input  logic              ex_is_branch,
  input  logic              ex_branch_ne,
  input  logic              ex_mem_read,
  input  logic              ex_mem_write,
  input  logic              ex_reg_write,
  input  logic              ex_halt,
  input  rv_pkg::reg_addr_t ex_rs1,
  input  rv_pkg::reg_addr_t ex_rs2,
  input  rv_pkg::reg_addr_t ex_rd,
  input  rv_pkg::word_t     ex_rs1_data,
  input  rv_pkg::word_t     ex_rs2_data,
  input  rv_pkg::word_t     ex_imm,
  input  rv_pkg::word_t     ex_pc,
  input  rv_pkg::reg_addr_t wb_rd,
  input  logic              wb_reg_write,
  input  rv_pkg::word_t     wb_data,
  output rv_pkg::reg_addr_t mem_rd,
  output logic              mem_reg_write,
  output logic              mem_mem_read,
  output logic              mem_mem_write,
  output logic              mem_halt,
  output rv_pkg::word_t     mem_alu_out,
  output rv_pkg::word_t     mem_store_data,
  output logic              redirect,
  output rv_pkg::word_t     redirect_pc
);

  rv_pkg::word_t opnd_a, opnd_b, alu_b, alu_out;
  logic          equal;

  // newest producer wins, x0 never forwarded
  function automatic rv_pkg::word_t fwd(input rv_pkg::reg_addr_t rs, input rv_pkg::word_t rf);
    if (rs != '0 && mem_reg_write && mem_rd == rs) return mem_alu_out;
    if (rs != '0 && wb_reg_write && wb_rd == rs) return wb_data;
    return rf;
  endfunction

  always_comb begin
    opnd_a = fwd(ex_rs1, ex_rs1_data);
    opnd_b = fwd(ex_rs2, ex_rs2_data);
  end

  assign alu_b = ex_use_imm ? ex_imm : opnd_b;

  always_comb begin
    case (ex_alu_op)
      rv_pkg::alu_add: alu_out = opnd_a + alu_b;
      rv_pkg::alu_sub: alu_out = opnd_a - alu_b;
      rv_pkg::alu_and: alu_out = opnd_a & alu_b;
      rv_pkg::alu_or:  alu_out = opnd_a | alu_b;
      rv_pkg::alu_slt: alu_out = {31'b0, $signed(opnd_a) < $signed(alu_b)};
      default:         alu_out = '0;
    endcase
  end

  // branch resolve, predicted not-taken so only taken redirects
  assign equal       = opnd_a == opnd_b;
  assign redirect    = ex_valid && ex_is_branch && (equal ^ ex_branch_ne);
  assign redirect_pc = ex_pc + ex_imm;

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset || !ex_valid) begin
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_halt      <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_halt      <= ex_halt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    mem_rd         <= ex_rd;
    mem_alu_out    <= alu_out;  // result or load/store address
    mem_store_data <= opnd_b;   // forwarded rs2 for sw
  end

  // taken branch comes from a real branch, and its younger slot is flushed
  redirect_valid_a: assert property (@(posedge clk) disable iff (reset)
    redirect |-> (ex_valid && ex_is_branch) ##1 !ex_valid);

endmodule

/* rtl/memory_writeback.sv */
// data memory is word addressed by byte address bits [7:2]; sub-word access unsupported
`timescale 1ns/1ns

module memory_writeback (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::word_t     mem_alu_out,
  input  rv_pkg::word_t     mem_store_data,
  input  rv_pkg::reg_addr_t mem_rd,
  input  logic              mem_reg_write,
  input  logic              mem_mem_read,
  input  logic              mem_mem_write,
  input  logic              mem_halt,
  output rv_pkg::reg_addr_t wb_rd,
  output logic              wb_reg_write,
  output rv_pkg::word_t     wb_data,
  output logic              is_halted
);

  rv_pkg::word_t dmem [rv_pkg::dmem_depth];
  logic [$clog2(rv_pkg::dmem_depth)-1:0] dmem_idx;
  rv_pkg::word_t load_data;
  rv_pkg::word_t wb_alu_out, wb_load_data;
  logic          wb_mem_read, wb_halt;

  assign dmem_idx  = mem_alu_out[$clog2(rv_pkg::dmem_depth)+1:2];
  assign load_data = dmem[dmem_idx];  // async read

  always_ff @(posedge clk) begin
    if (mem_mem_write) begin
      dmem[dmem_idx] <= mem_store_data;
    end
  end

  // MEM/WB control
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      wb_mem_read  <= 1'b0;
      wb_halt      <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
      wb_mem_read  <= mem_mem_read;
      wb_halt      <= mem_halt;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd        <= mem_rd;
    wb_alu_out   <= mem_alu_out;
    wb_load_data <= load_data;
  end

  assign wb_data = wb_mem_read ? wb_load_data : wb_alu_out;

  // sticky halt, one cycle after ecall reaches WB
  always_ff @(posedge clk) begin
    if (reset) begin
      is_halted <= 1'b0;
    end else if (wb_halt) begin
      is_halted <= 1'b1;
    end
  end

  // address from execute must land inside the array, word aligned
  dmem_range_a: assert property (@(posedge clk) disable iff (reset)
    (mem_mem_read || mem_mem_write) |->
      mem_alu_out < rv_pkg::dmem_depth * 4 && mem_alu_out[1:0] == 2'b00);

endmodule

/* rtl/rv_core.sv */
// 5-stage core, load the program through prog_* while reset is high; no external stalls
`timescale 1ns/1ns

module rv_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              prog_we,
  input  rv_pkg::word_t     prog_addr,
  input  rv_pkg::word_t     prog_data,
  input  rv_pkg::reg_addr_t dbg_addr,
  output rv_pkg::word_t     dbg_data,
  output logic              is_halted
);

  rv_pkg::word_t     if_inst, if_pc, redirect_pc;
  logic              stall, redirect;
  logic              ex_valid, ex_use_imm, ex_is_branch, ex_branch_ne;
  logic              ex_mem_read, ex_mem_write, ex_reg_write, ex_halt;
  rv_pkg::alu_op_e   ex_alu_op;
  rv_pkg::reg_addr_t ex_rs1, ex_rs2, ex_rd;
  rv_pkg::word_t     ex_rs1_data, ex_rs2_data, ex_imm, ex_pc;
  rv_pkg::reg_addr_t mem_rd, wb_rd;
  logic              mem_reg_write, mem_mem_read, mem_mem_write, mem_halt;
  rv_pkg::word_t     mem_alu_out, mem_store_data, wb_data;
  logic              wb_reg_write;

  // input side
  fetch_unit u_fetch (
    .clk, .reset, .prog_we, .prog_addr, .prog_data,
    .stall, .redirect, .redirect_pc, .if_inst, .if_pc
  );

  decode_unit u_decode (
    .clk, .reset, .if_inst, .if_pc, .redirect,
    .mem_rd, .mem_reg_write, .mem_mem_read,
    .wb_rd, .wb_reg_write, .wb_data, .dbg_addr, .dbg_data, .stall,
    .ex_valid, .ex_alu_op, .ex_use_imm, .ex_is_branch, .ex_branch_ne,
    .ex_mem_read, .ex_mem_write, .ex_reg_write, .ex_halt,
    .ex_rs1, .ex_rs2, .ex_rd, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_pc
  );

  execute_unit u_execute (
    .clk, .reset,
    .ex_valid, .ex_alu_op, .ex_use_imm, .ex_is_branch, .ex_branch_ne,
    .ex_mem_read, .ex_mem_write, .ex_reg_write, .ex_halt,
    .ex_rs1, .ex_rs2, .ex_rd, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_pc,
    .wb_rd, .wb_reg_write, .wb_data,
    .mem_rd, .mem_reg_write, .mem_mem_read, .mem_mem_write, .mem_halt,
    .mem_alu_out, .mem_store_data, .redirect, .redirect_pc
  );

  // output side
  memory_writeback u_memwb (
    .clk, .reset, .mem_alu_out, .mem_store_data, .mem_rd,
    .mem_reg_write, .mem_mem_read, .mem_mem_write, .mem_halt,
    .wb_rd, .wb_reg_write, .wb_data, .is_halted
  );

endmodule

/* verification/rv_core_tb.sv */
// each program fits in 16 words, ends on a halting ecall and sets every register it checks
`timescale 1ns/1ns

module rv_core_tb;

  localparam int n_rows     = 6;   // alu a, alu b, forwarding, memory, branches, ecall
  localparam int row_words  = 16;
  localparam int row_pairs  = 4;
  localparam int max_cycles = n_rows * (8 + 4 * row_words + 16);

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // sub
  localparam rv_pkg::word_t ecall_word = 32'h0000_0073;

  logic              clk;
  logic              reset;
  logic              prog_we;
  rv_pkg::word_t     prog_addr;
  rv_pkg::word_t     prog_data;
  rv_pkg::reg_addr_t dbg_addr;
  rv_pkg::word_t     dbg_data;
  logic              is_halted;

  // stimulus and expected values, one row per program
  rv_pkg::word_t     prog_tab [n_rows][row_words];
  int                prog_len [n_rows];
  rv_pkg::reg_addr_t exp_reg  [n_rows][row_pairs];
  rv_pkg::word_t     exp_val  [n_rows][row_pairs];
  int                exp_num  [n_rows];

  int err_count;
  int check_count;
  int cycle_count;

  rv_core DUT (
    .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .dbg_addr(dbg_addr), .dbg_data(dbg_data), .is_halted(is_halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // RV32I encoders
  function automatic rv_pkg::word_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::op_reg};
  endfunction

  function automatic rv_pkg::word_t i_word(input rv_pkg::opcode_e op, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic rv_pkg::word_t s_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::op_store};  // sw only
  endfunction

  function automatic rv_pkg::word_t b_word(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  task automatic append_inst(input int row, input rv_pkg::word_t w);
    prog_tab[row][prog_len[row]] = w;
    prog_len[row]++;
  endtask

  task automatic expect_reg(input int row, input int r, input int v);
    exp_reg[row][exp_num[row]] = r[4:0];
    exp_val[row][exp_num[row]] = v;
    exp_num[row]++;
  endtask

  // x17 = 10 then ecall
  task automatic halt_tail(input int row);
    append_inst(row, i_word(rv_pkg::op_imm, 3'b000, 17, 0, 10));
    append_inst(row, ecall_word);
  endtask

  task automatic build_table();
    for (int r = 0; r < n_rows; r++) begin
      prog_len[r] = 0;
      exp_num[r]  = 0;
      for (int w = 0; w < row_words; w++) begin
        prog_tab[r][w] = rv_pkg::nop_word;  // padding
      end
    end
    // row 0, addi add sub and a write to x0
    append_inst(0, i_word(rv_pkg::op_imm, 3'b000, 1, 0, 25));
    append_inst(0, i_word(rv_pkg::op_imm, 3'b000, 2, 0, -7));
    append_inst(0, i_word(rv_pkg::op_imm, 3'b000, 0, 0, 99));  // must vanish
    append_inst(0, r_word(f7_base, 3'b000, 5, 0, 1));          // x0 still reads zero
    append_inst(0, r_word(f7_base, 3'b000, 3, 1, 2));          // 25 + -7
    append_inst(0, r_word(f7_alt, 3'b000, 4, 1, 2));           // 25 - -7
    halt_tail(0);
    expect_reg(0, 3, 18);
    expect_reg(0, 4, 32);
    expect_reg(0, 5, 25);
    expect_reg(0, 1, 25);
    // row 1, and or slt
    append_inst(1, i_word(rv_pkg::op_imm, 3'b000, 5, 0, 12));
    append_inst(1, i_word(rv_pkg::op_imm, 3'b000, 6, 0, 10));
    append_inst(1, i_word(rv_pkg::op_imm, 3'b000, 10, 0, -3));
    append_inst(1, r_word(f7_base, 3'b111, 7, 5, 6));   // 1100 & 1010
    append_inst(1, r_word(f7_base, 3'b110, 8, 5, 6));   // 1100 | 1010
    append_inst(1, r_word(f7_base, 3'b010, 9, 10, 5));  // -3 < 12 signed
    append_inst(1, r_word(f7_base, 3'b010, 11, 5, 10));
    halt_tail(1);
    expect_reg(1, 7, 8);
    expect_reg(1, 8, 14);
    expect_reg(1, 9, 1);
    expect_reg(1, 11, 0);
    // row 2, back to back dependent chain
    append_inst(2, i_word(rv_pkg::op_imm, 3'b000, 1, 0, 5));
    append_inst(2, r_word(f7_base, 3'b000, 2, 1, 1));  // 10
    append_inst(2, r_word(f7_alt, 3'b000, 3, 2, 1));   // 10 - 5
    append_inst(2, r_word(f7_base, 3'b000, 4, 3, 2));  // 5 + 10
    append_inst(2, r_word(f7_base, 3'b000, 5, 4, 4));  // 15 + 15
    halt_tail(2);
    expect_reg(2, 2, 10);
    expect_reg(2, 3, 5);
    expect_reg(2, 4, 15);
    expect_reg(2, 5, 30);
    // row 3, sw then lw, each load feeding the next add
    append_inst(3, i_word(rv_pkg::op_imm, 3'b000, 1, 0, 123));
    append_inst(3, i_word(rv_pkg::op_imm, 3'b000, 2, 0, 16));
    append_inst(3, s_word(1, 2, 8));                            // mem[24] = 123
    append_inst(3, i_word(rv_pkg::op_load, 3'b010, 3, 2, 8));
    append_inst(3, r_word(f7_base, 3'b000, 4, 3, 1));           // load-use
    append_inst(3, i_word(rv_pkg::op_imm, 3'b000, 5, 0, 77));
    append_inst(3, s_word(5, 0, 0));
    append_inst(3, i_word(rv_pkg::op_load, 3'b010, 6, 0, 0));
    append_inst(3, r_word(f7_base, 3'b000, 7, 6, 6));
    halt_tail(3);
    expect_reg(3, 3, 123);
    expect_reg(3, 4, 246);
    expect_reg(3, 6, 77);
    expect_reg(3, 7, 154);
    // row 4, taken beq, taken bne, untaken beq
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 1, 0, 3));
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 2, 0, 3));
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 3, 0, 1));
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 4, 0, 2));
    append_inst(4, b_word(3'b000, 1, 2, 12));                   // pc 16 -> 28
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 3, 0, 50));  // skipped
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 4, 0, 60));  // skipped
    append_inst(4, b_word(3'b001, 1, 0, 12));                   // pc 28 -> 40
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 3, 0, 70));
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 4, 0, 80));
    append_inst(4, b_word(3'b000, 1, 0, 8));                    // 3 != 0, falls through
    append_inst(4, i_word(rv_pkg::op_imm, 3'b000, 5, 0, 9));
    halt_tail(4);
    expect_reg(4, 3, 1);
    expect_reg(4, 4, 2);
    expect_reg(4, 5, 9);
    expect_reg(4, 1, 3);
    // row 5, ecall as no-op, then halting ecall with trailing addis
    append_inst(5, i_word(rv_pkg::op_imm, 3'b000, 7, 0, 1));
    append_inst(5, i_word(rv_pkg::op_imm, 3'b000, 17, 0, 3));
    append_inst(5, ecall_word);                                  // x17 = 3, keeps going
    append_inst(5, i_word(rv_pkg::op_imm, 3'b000, 6, 0, 44));
    halt_tail(5);
    append_inst(5, i_word(rv_pkg::op_imm, 3'b000, 6, 0, 99));  // never issues
    append_inst(5, i_word(rv_pkg::op_imm, 3'b000, 7, 0, 55));
    expect_reg(5, 6, 44);
    expect_reg(5, 7, 1);
    expect_reg(5, 17, 10);
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t expected,
                            input rv_pkg::word_t actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[ERROR] %0t %s: expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // reset, load, run to halt, read back
  task automatic run_row(input int row);
    @(posedge clk);
    reset <= 1'b1;
    repeat (8) @(posedge clk);
    for (int w = 0; w < row_words; w++) begin
      prog_we   <= 1'b1;
      prog_addr <= w;
      prog_data <= prog_tab[row][w];
      @(posedge clk);
    end
    prog_we <= 1'b0;
    reset   <= 1'b0;  // last word still lands on this edge
    @(negedge clk);
    check_flag("is_halted", 1'b0, is_halted);
    while (is_halted !== 1'b1) begin
      @(negedge clk);  // bounded by the cycle counter
    end
    repeat (2) @(posedge clk);
    for (int p = 0; p < exp_num[row]; p++) begin
      @(posedge clk);
      dbg_addr <= exp_reg[row][p];
      @(negedge clk);
      check_word($sformatf("dbg_data x%0d", exp_reg[row][p]), exp_val[row][p], dbg_data);
    end
    check_flag("is_halted", 1'b1, is_halted);  // sticky through the readback
  endtask

  // watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the core never halted within %0d cycles", max_cycles);
      $display("checks: %0d, errors: %0d", check_count, err_count + 1);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    reset       = 1'b1;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    dbg_addr    = '0;
    err_count   = 0;
    check_count = 0;
    cycle_count = 0;
    build_table();
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/memory_writeback.sv
rtl/rv_core.sv
verification/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/decode_unit.sv
  - rtl/execute_unit.sv
  - rtl/memory_writeback.sv
  - rtl/rv_core.sv
  - target: simulation
    files:
      - verification/rv_core_tb.sv
